// File: source/mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// memory geometry.
`define MEM_DATA_W      64
`define MEM_ADDR_W      8
`define MEM_DEPTH       256
`define MEM_MASK_W      8
`define SKID_SIZE       2

// network side.
`define NOC_DATA_W      128
`define NOC_COORD_W     4
`define MEM_TILE_X      2
`define MEM_TILE_Y      2

// apb register map.
`define REG_CTRL_ADDR    8'h00
`define REG_LIMIT_ADDR   8'h04
`define REG_RD_CNT_ADDR  8'h08
`define REG_WR_CNT_ADDR  8'h0C
`define REG_ERR_CNT_ADDR 8'h10

`endif

// File: source/noc_pkg.sv
`default_nettype none
`include "mem_settings.svh"

package noc_pkg;

    // field widths of the flit that are fixed by the protocol.
    localparam int MSG_W    = 2;
    localparam int TAG_W    = 8;
    localparam int STATUS_W = 1;

    // the reserved field pads the flit out to the full channel width.
    localparam int USED_W = MSG_W + 4 * `NOC_COORD_W + TAG_W + STATUS_W
                          + `MEM_ADDR_W + `MEM_MASK_W + `MEM_DATA_W;
    localparam int RSVD_W = `NOC_DATA_W - USED_W;

    typedef enum logic [MSG_W-1:0] {
        MSG_RD_REQ  = 2'd0,
        MSG_WR_REQ  = 2'd1,
        MSG_RD_RESP = 2'd2,
        MSG_WR_RESP = 2'd3
    } noc_msg_e;

    typedef enum logic [STATUS_W-1:0] {
        ST_OK       = 1'b0,
        ST_ADDR_ERR = 1'b1
    } noc_status_e;

    // one layout for requests and responses with the msb first.
    typedef struct packed {
        noc_msg_e                   msg;
        logic [`NOC_COORD_W-1:0]    dst_x;
        logic [`NOC_COORD_W-1:0]    dst_y;
        logic [`NOC_COORD_W-1:0]    src_x;
        logic [`NOC_COORD_W-1:0]    src_y;
        logic [TAG_W-1:0]           tag;
        noc_status_e                status;
        logic [RSVD_W-1:0]          rsvd;
        logic [`MEM_ADDR_W-1:0]     addr;
        logic [`MEM_MASK_W-1:0]     mask;
        logic [`MEM_DATA_W-1:0]     data;
    } noc_flit_t;

endpackage

`default_nettype wire

// File: source/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // ==================================================
    // controller
    // ==================================================
    typedef enum logic [2:0] {
        CS_IDLE    = 3'd0,
        CS_ISSUE   = 3'd1,  // access on the memory port.
        CS_RD_WAIT = 3'd2,  // waiting for read data.
        CS_RESP    = 3'd3   // holding the response flit.
    } ctrl_state_e;

    // ==================================================
    // apb register index
    // ==================================================
    typedef enum logic [2:0] {
        REG_CTRL    = 3'd0,
        REG_LIMIT   = 3'd1,
        REG_RD_CNT  = 3'd2,
        REG_WR_CNT  = 3'd3,
        REG_ERR_CNT = 3'd4,
        REG_NONE    = 3'd7
    } cfg_reg_e;

endpackage

`default_nettype wire

// File: source/mem_port_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_settings.svh"

interface mem_port_if;

    // request side.
    logic                       write_en;
    logic                       read_en;
    logic [`MEM_ADDR_W-1:0]     addr;
    logic [`MEM_DATA_W-1:0]     wr_data;
    logic [`MEM_MASK_W-1:0]     byte_en;
    logic                       rdy;

    // read data return.
    logic                       rd_data_val;
    logic [`MEM_DATA_W-1:0]     rd_data;
    logic                       rd_data_rdy;

    modport issuer (
        output write_en, read_en, addr, wr_data, byte_en, rd_data_rdy,
        input  rdy, rd_data_val, rd_data
    );

    modport server (
        input  write_en, read_en, addr, wr_data, byte_en, rd_data_rdy,
        output rdy, rd_data_val, rd_data
    );

endinterface

`default_nettype wire

// File: source/mem_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_settings.svh"

module mem_cfg_regs (
     input  logic                   clk
    ,input  logic                   rst_n

    ,input  logic                   psel
    ,input  logic                   penable
    ,input  logic                   pwrite
    ,input  logic [7:0]             paddr
    ,input  logic [31:0]            pwdata
    ,output logic [31:0]            prdata
    ,output logic                   pready

    ,output logic                   enable
    ,output logic [`MEM_ADDR_W:0]   addr_limit

    ,input  logic                   rd_done
    ,input  logic                   wr_done
    ,input  logic                   err_done
);
    import mem_pkg::*;

    cfg_reg_e       reg_idx;
    logic           apb_wr;
    logic           apb_rd;
    logic [2:0]     done;
    logic [15:0]    cnt [3];    // rd, wr, err.

    assign pready = 1'b1;       // no wait states.
    assign apb_wr = psel & penable & pwrite;
    assign apb_rd = psel & penable & ~pwrite;
    assign done   = {err_done, wr_done, rd_done};

    always_comb begin
        case (paddr)
            `REG_CTRL_ADDR:    reg_idx = REG_CTRL;
            `REG_LIMIT_ADDR:   reg_idx = REG_LIMIT;
            `REG_RD_CNT_ADDR:  reg_idx = REG_RD_CNT;
            `REG_WR_CNT_ADDR:  reg_idx = REG_WR_CNT;
            `REG_ERR_CNT_ADDR: reg_idx = REG_ERR_CNT;
            default:           reg_idx = REG_NONE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enable     <= 1'b0;
            addr_limit <= (`MEM_ADDR_W+1)'(`MEM_DEPTH);
        end else if (apb_wr) begin
            if (reg_idx == REG_CTRL) begin
                enable <= pwdata[0];
            end
            if (reg_idx == REG_LIMIT) begin
                addr_limit <= pwdata[`MEM_ADDR_W:0];
            end
        end
    end

    // saturating event counters that apb writes cannot touch.
    always_ff @(posedge clk) begin
        for (int i = 0; i < 3; i++) begin
            if (!rst_n) begin
                cnt[i] <= '0;
            end else if (done[i] && cnt[i] != 16'hffff) begin
                cnt[i] <= cnt[i] + 16'd1;
            end
        end
    end

    always_comb begin
        prdata = '0;
        if (apb_rd) begin
            case (reg_idx)
                REG_CTRL:    prdata = {31'd0, enable};
                REG_LIMIT:   prdata = {{(31-`MEM_ADDR_W){1'b0}}, addr_limit};
                REG_RD_CNT:  prdata = {16'd0, cnt[0]};
                REG_WR_CNT:  prdata = {16'd0, cnt[1]};
                REG_ERR_CNT: prdata = {16'd0, cnt[2]};
                default:     prdata = '0;
            endcase
        end
    end

    a_penable_psel: assert property (@(posedge clk) disable iff (!rst_n)
        penable |-> psel);

endmodule

`default_nettype wire

// File: source/mem_controller.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_settings.svh"

module mem_controller (
     input  logic                   clk
    ,input  logic                   rst_n

    ,input  logic                   req_val
    ,input  noc_pkg::noc_flit_t     req_data
    ,output logic                   req_rdy

    ,output logic                   rd_resp_val
    ,output noc_pkg::noc_flit_t     rd_resp_data
    ,input  logic                   rd_resp_rdy

    ,output logic                   wr_resp_val
    ,output noc_pkg::noc_flit_t     wr_resp_data
    ,input  logic                   wr_resp_rdy

    ,input  logic                   enable
    ,input  logic [`MEM_ADDR_W:0]   addr_limit

    ,output logic                   rd_done
    ,output logic                   wr_done
    ,output logic                   err_done

    ,mem_port_if.issuer             mem
);
    import noc_pkg::*;
    import mem_pkg::*;

    ctrl_state_e            state;
    noc_status_e            err_q;
    noc_flit_t              req_q;
    noc_flit_t              resp;
    logic [`MEM_DATA_W-1:0] rdata_q;
    logic                   is_rd;
    logic                   out_of_range;
    logic                   resp_taken;

    assign is_rd        = (req_q.msg == MSG_RD_REQ);
    assign out_of_range = ({1'b0, req_data.addr} >= addr_limit);

    // ==================================================
    // request side
    // ==================================================
    assign req_rdy = (state == CS_IDLE) && enable;

    assign mem.write_en    = (state == CS_ISSUE) && !is_rd;
    assign mem.read_en     = (state == CS_ISSUE) && is_rd;
    assign mem.addr        = req_q.addr;
    assign mem.wr_data     = req_q.data;
    assign mem.byte_en     = req_q.mask;
    assign mem.rd_data_rdy = (state == CS_RD_WAIT);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= CS_IDLE;
            err_q <= ST_OK;
        end else begin
            case (state)
                CS_IDLE: begin
                    if (req_val && req_rdy) begin
                        err_q <= out_of_range ? ST_ADDR_ERR : ST_OK;
                        state <= out_of_range ? CS_RESP : CS_ISSUE;
                    end
                end
                CS_ISSUE: begin
                    if (mem.rdy) begin
                        state <= is_rd ? CS_RD_WAIT : CS_RESP;
                    end
                end
                CS_RD_WAIT: begin
                    if (mem.rd_data_val) begin
                        state <= CS_RESP;
                    end
                end
                CS_RESP: begin
                    if (resp_taken) begin
                        state <= CS_IDLE;
                    end
                end
                default: state <= CS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_val && req_rdy) begin
            req_q <= req_data;
        end
        if (state == CS_RD_WAIT && mem.rd_data_val) begin
            rdata_q <= mem.rd_data;
        end
    end

    // ==================================================
    // response side
    // ==================================================
    always_comb begin
        resp        = '0;
        resp.msg    = is_rd ? MSG_RD_RESP : MSG_WR_RESP;
        resp.dst_x  = req_q.src_x;
        resp.dst_y  = req_q.src_y;
        resp.src_x  = `NOC_COORD_W'(`MEM_TILE_X);
        resp.src_y  = `NOC_COORD_W'(`MEM_TILE_Y);
        resp.tag    = req_q.tag;
        resp.status = err_q;
        resp.addr   = req_q.addr;
        if (is_rd && err_q == ST_OK) begin
            resp.data = rdata_q;    // read errors return zero.
        end
    end

    assign rd_resp_val  = (state == CS_RESP) && is_rd;
    assign wr_resp_val  = (state == CS_RESP) && !is_rd;
    assign rd_resp_data = resp;
    assign wr_resp_data = resp;

    assign resp_taken = (rd_resp_val && rd_resp_rdy) || (wr_resp_val && wr_resp_rdy);
    assign rd_done    = rd_resp_val && rd_resp_rdy && err_q == ST_OK;
    assign wr_done    = wr_resp_val && wr_resp_rdy && err_q == ST_OK;
    assign err_done   = resp_taken && err_q == ST_ADDR_ERR;

    a_one_resp: assert property (@(posedge clk) disable iff (!rst_n)
        !(rd_resp_val && wr_resp_val));

    a_rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rd_resp_val && !rd_resp_rdy |=> rd_resp_val && $stable(rd_resp_data));

    a_wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wr_resp_val && !wr_resp_rdy |=> wr_resp_val && $stable(wr_resp_data));

endmodule

`default_nettype wire

// File: source/mem_skid_wrap.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_settings.svh"

module mem_skid_wrap (
     input  logic                   clk
    ,input  logic                   rst_n

    ,mem_port_if.server             up

    ,output logic                   ram_en
    ,output logic                   ram_wr_en
    ,output logic [`MEM_ADDR_W-1:0] ram_addr
    ,output logic [`MEM_DATA_W-1:0] ram_din
    ,output logic [`MEM_MASK_W-1:0] ram_wr_mask
    ,input  logic                   ram_dout_val
    ,input  logic [`MEM_DATA_W-1:0] ram_dout
);
    localparam int SKID  = `SKID_SIZE;
    localparam int PTR_W = (SKID > 1) ? $clog2(SKID) : 1;
    localparam int CNT_W = $clog2(SKID + 1);

    logic [`MEM_DATA_W-1:0] buf_mem [SKID];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [CNT_W-1:0]       fifo_cnt;
    logic [CNT_W-1:0]       occ;        // reads in flight plus words held.
    logic [CNT_W-1:0]       occ_next;
    logic                   rdy_q;
    logic                   fifo_empty;
    logic                   rd_take;
    logic                   out_take;
    logic                   push;
    logic                   pop;

    // requests go straight through to the ram.
    assign ram_en      = (up.write_en | up.read_en) & rdy_q;
    assign ram_wr_en   = up.write_en;
    assign ram_addr    = up.addr;
    assign ram_din     = up.wr_data;
    assign ram_wr_mask = up.byte_en;

    assign up.rdy = rdy_q;
    assign rd_take = up.read_en & rdy_q;

    // ram output bypasses the buffer when it is empty.
    assign fifo_empty     = (fifo_cnt == '0);
    assign up.rd_data_val = !fifo_empty | ram_dout_val;
    assign up.rd_data     = fifo_empty ? ram_dout : buf_mem[rd_ptr];
    assign out_take       = up.rd_data_val & up.rd_data_rdy;
    assign pop            = !fifo_empty & up.rd_data_rdy;
    assign push           = ram_dout_val & !(fifo_empty & up.rd_data_rdy);

    assign occ_next = occ + CNT_W'(rd_take) - CNT_W'(out_take);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            occ      <= '0;
            rdy_q    <= 1'b0;
            fifo_cnt <= '0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
        end else begin
            occ      <= occ_next;
            rdy_q    <= (occ_next < CNT_W'(SKID));
            fifo_cnt <= fifo_cnt + CNT_W'(push) - CNT_W'(pop);
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(SKID - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(SKID - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            buf_mem[wr_ptr] <= ram_dout;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> fifo_cnt < CNT_W'(SKID));

endmodule

`default_nettype wire

// File: source/byte_mask_ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_settings.svh"

module byte_mask_ram (
     input  logic                   clk
    ,input  logic                   rst_n
    ,input  logic                   en
    ,input  logic                   wr_en
    ,input  logic [`MEM_ADDR_W-1:0] addr
    ,input  logic [`MEM_DATA_W-1:0] din
    ,input  logic [`MEM_MASK_W-1:0] wr_mask
    ,output logic                   dout_val
    ,output logic [`MEM_DATA_W-1:0] dout
);
    logic [`MEM_DATA_W-1:0] mem [`MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (en && wr_en) begin
            for (int b = 0; b < `MEM_MASK_W; b++) begin
                if (wr_mask[b]) begin
                    mem[addr][b*8 +: 8] <= din[b*8 +: 8];   // only enabled lanes.
                end
            end
        end
        if (en && !wr_en) begin
            dout <= mem[addr];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dout_val <= 1'b0;
        end else begin
            dout_val <= en && !wr_en;   // one cycle per read.
        end
    end

endmodule

`default_nettype wire

// File: source/noc_mem_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_settings.svh"

module noc_mem_top (
     input  logic                   clk
    ,input  logic                   rst_n

    ,input  logic                   psel
    ,input  logic                   penable
    ,input  logic                   pwrite
    ,input  logic [7:0]             paddr
    ,input  logic [31:0]            pwdata
    ,output logic [31:0]            prdata
    ,output logic                   pready

    ,input  logic                   req_val
    ,input  logic [`NOC_DATA_W-1:0] req_data
    ,output logic                   req_rdy

    ,output logic                   rd_resp_val
    ,output logic [`NOC_DATA_W-1:0] rd_resp_data
    ,input  logic                   rd_resp_rdy

    ,output logic                   wr_resp_val
    ,output logic [`NOC_DATA_W-1:0] wr_resp_data
    ,input  logic                   wr_resp_rdy
);
    import noc_pkg::*;

    noc_flit_t              req_flit;
    noc_flit_t              rd_resp_flit;
    noc_flit_t              wr_resp_flit;
    logic                   enable;
    logic [`MEM_ADDR_W:0]   addr_limit;
    logic                   rd_done;
    logic                   wr_done;
    logic                   err_done;
    logic                   ram_en;
    logic                   ram_wr_en;
    logic [`MEM_ADDR_W-1:0] ram_addr;
    logic [`MEM_DATA_W-1:0] ram_din;
    logic [`MEM_MASK_W-1:0] ram_wr_mask;
    logic                   ram_dout_val;
    logic [`MEM_DATA_W-1:0] ram_dout;

    assign req_flit     = noc_flit_t'(req_data);
    assign rd_resp_data = rd_resp_flit;
    assign wr_resp_data = wr_resp_flit;

    mem_port_if mem_port ();

    mem_cfg_regs cfg (
         .clk(clk), .rst_n(rst_n)
        ,.psel(psel), .penable(penable), .pwrite(pwrite)
        ,.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready)
        ,.enable(enable), .addr_limit(addr_limit)
        ,.rd_done(rd_done), .wr_done(wr_done), .err_done(err_done)
    );

    mem_controller ctrl (
         .clk(clk), .rst_n(rst_n)
        ,.req_val(req_val), .req_data(req_flit), .req_rdy(req_rdy)
        ,.rd_resp_val(rd_resp_val), .rd_resp_data(rd_resp_flit)
        ,.rd_resp_rdy(rd_resp_rdy)
        ,.wr_resp_val(wr_resp_val), .wr_resp_data(wr_resp_flit)
        ,.wr_resp_rdy(wr_resp_rdy)
        ,.enable(enable), .addr_limit(addr_limit)
        ,.rd_done(rd_done), .wr_done(wr_done), .err_done(err_done)
        ,.mem(mem_port.issuer)
    );

    mem_skid_wrap wrap (
         .clk(clk), .rst_n(rst_n)
        ,.up(mem_port.server)
        ,.ram_en(ram_en), .ram_wr_en(ram_wr_en), .ram_addr(ram_addr)
        ,.ram_din(ram_din), .ram_wr_mask(ram_wr_mask)
        ,.ram_dout_val(ram_dout_val), .ram_dout(ram_dout)
    );

    byte_mask_ram ram (
         .clk(clk), .rst_n(rst_n)
        ,.en(ram_en), .wr_en(ram_wr_en), .addr(ram_addr)
        ,.din(ram_din), .wr_mask(ram_wr_mask)
        ,.dout_val(ram_dout_val), .dout(ram_dout)
    );

endmodule

`default_nettype wire

// File: dv/tb_noc_mem_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_settings.svh"

module tb_noc_mem_top;
    import noc_pkg::*;

    localparam int NW      = 8;
    localparam int TIMEOUT = 400;

    logic                   clk;
    logic                   rst_n;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [7:0]             paddr;
    logic [31:0]            pwdata;
    logic [31:0]            prdata;
    logic                   pready;
    logic                   req_val;
    logic [`NOC_DATA_W-1:0] req_data;
    logic                   req_rdy;
    logic                   rd_resp_val;
    logic [`NOC_DATA_W-1:0] rd_resp_data;
    logic                   rd_resp_rdy;
    logic                   wr_resp_val;
    logic [`NOC_DATA_W-1:0] wr_resp_data;
    logic                   wr_resp_rdy;

    integer                 seed;
    logic [31:0]            rnd;
    logic                   enabled;
    logic [`MEM_ADDR_W:0]   cur_limit;
    logic [`MEM_DATA_W-1:0] shadow [`MEM_DEPTH];
    noc_flit_t              exp_rd_q [$];
    noc_flit_t              exp_wr_q [$];
    int                     n_rd;
    int                     n_wr;
    int                     n_err;
    noc_flit_t              req_flit;
    logic                   wr_in_range;
    logic [1:0]             wr_lat;     // in-range write handshakes delayed by one and two.
    logic [`MEM_DATA_W-1:0] wdata [2*NW];
    logic [`MEM_MASK_W-1:0] wmask [NW];
    logic [31:0]            rdata;

    noc_mem_top uut (
         .clk(clk), .rst_n(rst_n)
        ,.psel(psel), .penable(penable), .pwrite(pwrite)
        ,.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready)
        ,.req_val(req_val), .req_data(req_data), .req_rdy(req_rdy)
        ,.rd_resp_val(rd_resp_val), .rd_resp_data(rd_resp_data), .rd_resp_rdy(rd_resp_rdy)
        ,.wr_resp_val(wr_resp_val), .wr_resp_data(wr_resp_data), .wr_resp_rdy(wr_resp_rdy)
    );

    always #20 clk = ~clk;

    // response back-pressure about one cycle in four.
    always @(posedge clk) begin
        #2;
        if (enabled) begin
            rnd = $random(seed);
            rd_resp_rdy = rnd[0] | rnd[1];
            wr_resp_rdy = rnd[2] | rnd[3];
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] got);
        assert (exp === got)
        else fail_run($sformatf("mismatch at %0t: %s expected %h got %h", $time, name, exp, got));
    endtask

    // ==================================================
    // drivers
    // ==================================================
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        int cycles;
        cycles  = 0;
        psel    = 1'b1;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        penable = 1'b0;
        @(posedge clk);
        #2;
        penable = 1'b1;
        @(negedge clk);
        while (!pready) begin
            cycles++;
            if (cycles > TIMEOUT) fail_run("APB write saw no pready before the timeout");
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        int cycles;
        cycles  = 0;
        psel    = 1'b1;
        pwrite  = 1'b0;
        paddr   = addr;
        penable = 1'b0;
        @(posedge clk);
        #2;
        penable = 1'b1;
        @(negedge clk);
        while (!pready) begin
            cycles++;
            if (cycles > TIMEOUT) fail_run("APB read saw no pready before the timeout");
            @(negedge clk);
        end
        data = prdata;      // prdata is stable mid access phase.
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic send_flit(input noc_msg_e msg, input logic [7:0] addr,
                             input logic [7:0] mask, input logic [63:0] data,
                             input logic [7:0] tag);
        noc_flit_t f;
        int        cycles;
        f       = '0;
        f.msg   = msg;
        f.dst_x = `NOC_COORD_W'(`MEM_TILE_X);
        f.dst_y = `NOC_COORD_W'(`MEM_TILE_Y);
        f.src_x = tag[3:0];
        f.src_y = tag[7:4];
        f.tag   = tag;
        f.addr  = addr;
        f.mask  = mask;
        f.data  = data;
        cycles   = 0;
        req_val  = 1'b1;
        req_data = f;
        @(negedge clk);
        while (!req_rdy) begin
            cycles++;
            if (cycles > TIMEOUT) fail_run("request flit was not accepted before the timeout");
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        req_val  = 1'b0;
        req_data = '0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_rd_q.size() != 0 || exp_wr_q.size() != 0) begin
            cycles++;
            if (cycles > TIMEOUT) fail_run("responses still outstanding after the timeout");
            @(posedge clk);
            #2;
        end
    endtask

    // ==================================================
    // reference model
    // ==================================================
    task automatic accept_request(input noc_flit_t f);
        noc_flit_t e;
        logic      ok;
        ok       = ({1'b0, f.addr} < cur_limit);
        e        = '0;
        e.dst_x  = f.src_x;
        e.dst_y  = f.src_y;
        e.src_x  = `NOC_COORD_W'(`MEM_TILE_X);
        e.src_y  = `NOC_COORD_W'(`MEM_TILE_Y);
        e.tag    = f.tag;
        e.status = ok ? ST_OK : ST_ADDR_ERR;
        if (f.msg == MSG_RD_REQ) begin
            e.msg = MSG_RD_RESP;
            if (ok) e.data = shadow[f.addr];
            exp_rd_q.push_back(e);
        end else begin
            e.msg = MSG_WR_RESP;
            for (int b = 0; b < `MEM_MASK_W; b++) begin
                if (ok && f.mask[b]) shadow[f.addr][b*8 +: 8] = f.data[b*8 +: 8];
            end
            exp_wr_q.push_back(e);
        end
    endtask

    task automatic check_response(input noc_flit_t got, input logic is_rd);
        noc_flit_t e;
        string     ch;
        ch = is_rd ? "rd_resp_data" : "wr_resp_data";
        if ((is_rd && exp_rd_q.size() == 0) || (!is_rd && exp_wr_q.size() == 0)) begin
            fail_run({ch, " carried a response with no request outstanding"});
        end else begin
            if (is_rd) e = exp_rd_q.pop_front();
            else       e = exp_wr_q.pop_front();
            check_eq({ch, ".msg"}, e.msg, got.msg);
            check_eq({ch, ".dst_x"}, e.dst_x, got.dst_x);
            check_eq({ch, ".dst_y"}, e.dst_y, got.dst_y);
            check_eq({ch, ".src_x"}, e.src_x, got.src_x);
            check_eq({ch, ".src_y"}, e.src_y, got.src_y);
            check_eq({ch, ".tag"}, e.tag, got.tag);
            check_eq({ch, ".status"}, e.status, got.status);
            if (is_rd) check_eq({ch, ".data"}, e.data, got.data);
            if (e.status == ST_ADDR_ERR) n_err++;
            else if (is_rd) n_rd++;
            else n_wr++;
        end
    endtask

    // handshakes complete at the next rising edge.
    always @(negedge clk) begin
        if (rst_n) begin
            if (req_val && req_rdy) accept_request(noc_flit_t'(req_data));
            if (rd_resp_val && rd_resp_rdy) check_response(noc_flit_t'(rd_resp_data), 1'b1);
            if (wr_resp_val && wr_resp_rdy) check_response(noc_flit_t'(wr_resp_data), 1'b0);
        end
    end

    assign req_flit    = noc_flit_t'(req_data);
    assign wr_in_range = req_val && req_rdy && req_flit.msg == MSG_WR_REQ
                         && {1'b0, req_flit.addr} < cur_limit;

    always @(posedge clk) begin
        wr_lat <= rst_n ? {wr_lat[0], wr_in_range} : 2'b00;
    end

    // ==================================================
    // protocol assertions
    // ==================================================
    a_quiet_until_enabled: assert property (@(posedge clk) disable iff (!rst_n)
        !enabled |-> !req_rdy && !rd_resp_val && !wr_resp_val)
        else fail_run($sformatf("mismatch at %0t: %s expected 000 got %b%b%b", $time,
                                "req_rdy,rd_resp_val,wr_resp_val", req_rdy, rd_resp_val,
                                wr_resp_val));

    a_wr_not_early: assert property (@(posedge clk) disable iff (!rst_n)
        wr_lat[0] |-> !wr_resp_val)
        else fail_run($sformatf("mismatch at %0t: wr_resp_val expected 0 got 1", $time));

    a_wr_on_time: assert property (@(posedge clk) disable iff (!rst_n)
        wr_lat[1] |-> wr_resp_val)
        else fail_run($sformatf("mismatch at %0t: wr_resp_val expected 1 got 0", $time));

    a_rd_held: assert property (@(posedge clk) disable iff (!rst_n)
        rd_resp_val && !rd_resp_rdy |=> rd_resp_val && $stable(rd_resp_data))
        else fail_run("read response was dropped or changed while rd_resp_rdy was low");

    a_wr_held: assert property (@(posedge clk) disable iff (!rst_n)
        wr_resp_val && !wr_resp_rdy |=> wr_resp_val && $stable(wr_resp_data))
        else fail_run("write response was dropped or changed while wr_resp_rdy was low");

    a_no_accept_held: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_resp_val && !rd_resp_rdy) || (wr_resp_val && !wr_resp_rdy) |-> !req_rdy)
        else fail_run("req_rdy was high while a response was held");

    // ==================================================
    // stimulus
    // ==================================================
    initial begin
        seed        = 32'h47b4;
        clk         = 1'b0;
        rst_n       = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        req_val     = 1'b0;
        req_data    = '0;
        rd_resp_rdy = 1'b0;
        wr_resp_rdy = 1'b0;
        enabled     = 1'b0;
        cur_limit   = (`MEM_ADDR_W+1)'(`MEM_DEPTH);
        n_rd        = 0;
        n_wr        = 0;
        n_err       = 0;
        for (int i = 0; i < `MEM_DEPTH; i++) shadow[i] = '0;
        for (int i = 0; i < 2*NW; i++) wdata[i] = {$random(seed), $random(seed)};
        for (int i = 0; i < NW; i++) wmask[i] = 8'($random(seed));

        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        repeat (4) @(posedge clk);
        #2;
        apb_read(`REG_CTRL_ADDR, rdata);
        check_eq("prdata CTRL", 64'd0, rdata);
        apb_read(`REG_LIMIT_ADDR, rdata);
        check_eq("prdata LIMIT", 64'(`MEM_DEPTH), rdata);
        apb_write(`REG_CTRL_ADDR, 32'd1);
        enabled = 1'b1;

        // full words first, then partial masks over them.
        for (int i = 0; i < NW; i++) begin
            send_flit(MSG_WR_REQ, 8'(i*7 + 3), 8'hff, wdata[i], 8'(i));
        end
        for (int i = 0; i < NW; i++) begin
            send_flit(MSG_WR_REQ, 8'(i*7 + 3), wmask[i], wdata[NW+i], 8'(8'h20 + i));
        end
        for (int i = 0; i < NW; i++) begin
            send_flit(MSG_RD_REQ, 8'(i*7 + 3), 8'h00, 64'd0, 8'(8'h40 + i));
        end
        // words that sit above the limit once it is lowered.
        send_flit(MSG_WR_REQ, 8'h40, 8'hff, ~wdata[1], 8'h7e);
        send_flit(MSG_WR_REQ, 8'h80, 8'hff, ~wdata[0], 8'h7f);
        wait_drain();

        apb_write(`REG_LIMIT_ADDR, 32'h40);
        cur_limit = 9'h040;
        send_flit(MSG_RD_REQ, 8'h40, 8'h00, 64'd0, 8'h81);
        send_flit(MSG_WR_REQ, 8'h80, 8'hff, wdata[0], 8'h82);
        send_flit(MSG_RD_REQ, 8'hff, 8'h00, 64'd0, 8'h83);
        send_flit(MSG_WR_REQ, 8'h40, 8'h0f, wdata[1], 8'h84);
        send_flit(MSG_RD_REQ, 8'd3, 8'h00, 64'd0, 8'h85);
        send_flit(MSG_RD_REQ, 8'd52, 8'h00, 64'd0, 8'h86);
        wait_drain();

        // the rejected writes must have left these words alone.
        apb_write(`REG_LIMIT_ADDR, 32'(`MEM_DEPTH));
        cur_limit = (`MEM_ADDR_W+1)'(`MEM_DEPTH);
        send_flit(MSG_RD_REQ, 8'h40, 8'h00, 64'd0, 8'h87);
        send_flit(MSG_RD_REQ, 8'h80, 8'h00, 64'd0, 8'h88);
        wait_drain();

        apb_read(`REG_RD_CNT_ADDR, rdata);
        check_eq("prdata RD_CNT", 64'(n_rd), rdata);
        apb_read(`REG_WR_CNT_ADDR, rdata);
        check_eq("prdata WR_CNT", 64'(n_wr), rdata);
        apb_read(`REG_ERR_CNT_ADDR, rdata);
        check_eq("prdata ERR_CNT", 64'(n_err), rdata);

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+source
source/noc_pkg.sv
source/mem_pkg.sv
source/mem_port_if.sv
source/mem_cfg_regs.sv
source/mem_controller.sv
source/mem_skid_wrap.sv
source/byte_mask_ram.sv
source/noc_mem_top.sv
dv/tb_noc_mem_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_noc_mem_top
DUT_TOP   ?= noc_mem_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
